// ==== source/knight_cmd_pkg.sv ====
`default_nettype none

// Command word layout and response codes shared by the command path
package knight_cmd_pkg;

  //////////////////////////////////////////////////
  // Opcodes in bits 15:12 of the command word
  //////////////////////////////////////////////////
  // Any code not listed here is rejected with a NAK
  typedef enum logic [3:0] {
    OP_CAL_GYRO = 4'd2,
    OP_MOVE     = 4'd4,
    OP_KNIGHT   = 4'd6
  } cmd_op_t;

  // Field positions within the 16-bit command
  localparam int CMD_OP_MSB  = 15;
  localparam int CMD_OP_LSB  = 12;
  localparam int CMD_HDG_MSB = 11;
  localparam int CMD_HDG_LSB = 4;
  localparam int CMD_ARG_MSB = 3;
  localparam int CMD_ARG_LSB = 0;

  //////////////////////////////////////////////////
  // Response bytes
  //////////////////////////////////////////////////
  // Positive acknowledge when the command ran to completion
  localparam logic [7:0] RESP_ACK = 8'hA5;
  // Negative acknowledge for a clipped move or a bad command
  localparam logic [7:0] RESP_NAK = 8'h5A;

endpackage

`default_nettype wire

// ==== source/knight_board_pkg.sv ====
`default_nettype none

// Board geometry, headings, motion timing and requester tags
package knight_board_pkg;

  // Coordinates run 0..BOARD_MAX on both axes
  localparam int COORD_W = 3;
  localparam logic [COORD_W-1:0] BOARD_MAX = 3'd4;
  localparam logic [COORD_W-1:0] START_XX  = 3'd2;
  localparam logic [COORD_W-1:0] START_YY  = 3'd2;

  // Square count width, matching the command argument field
  localparam int SQ_W = 4;
  // Knight-move index width and the two leg lengths
  localparam int KNIGHT_IDX_W = 3;
  localparam logic [SQ_W-1:0] KNIGHT_LONG  = 4'd2;
  localparam logic [SQ_W-1:0] KNIGHT_SHORT = 4'd1;

  // Travel directions as seen by the executor
  typedef enum logic [1:0] {DIR_NORTH, DIR_WEST, DIR_SOUTH, DIR_EAST} dir_t;

  // Heading codes carried in the command word
  localparam logic [7:0] HDG_NORTH = 8'h00;
  localparam logic [7:0] HDG_WEST  = 8'h3F;
  localparam logic [7:0] HDG_SOUTH = 8'h7F;
  localparam logic [7:0] HDG_EAST  = 8'hBF;

  // Motion and calibration timing in clock cycles
  localparam int SQUARE_CYCLES = 16;
  localparam int SQ_TMR_W      = $clog2(SQUARE_CYCLES);
  localparam int CAL_CYCLES    = 64;
  localparam int CAL_CNT_W     = $clog2(CAL_CYCLES);

  // Owner of the move currently held by the executor
  typedef enum logic {REQ_DECODER, REQ_TOUR} req_tag_t;

endpackage

`default_nettype wire

// ==== source/cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// Accepts one command at a time and answers it with one response byte
module cmd_decoder
  import knight_cmd_pkg::*, knight_board_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic [15:0]             cmd,
  input  wire logic                    cmd_rdy,
  input  wire logic                    dec_grant,
  input  wire logic                    dec_done,
  input  wire logic                    dec_clipped,
  input  wire logic                    leg_done_all,
  input  wire logic                    leg_clipped,
  output logic                         busy,
  output logic                         dec_req,
  output dir_t                         dec_dir,
  output logic [SQ_W-1:0]              dec_squares,
  output logic                         tour_go,
  output logic [KNIGHT_IDX_W-1:0]      tour_index,
  output logic [7:0]                   resp,
  output logic                         resp_rdy
);

  typedef enum logic [2:0] {IDLE, CAL, MOVE_WAIT, TOUR_WAIT, RESPOND} dec_state_t;

  dec_state_t           state;
  cmd_op_t              op;
  dir_t                 hdg_dir;
  logic                 hdg_ok;
  logic [CAL_CNT_W-1:0] cal_cnt;

  //////////////////////////////////////////////////
  // Field decode straight off the command input
  //////////////////////////////////////////////////
  assign op = cmd_op_t'(cmd[CMD_OP_MSB:CMD_OP_LSB]);

  // Only the four cardinal heading codes are legal
  always_comb begin
    hdg_ok  = 1'b1;
    hdg_dir = DIR_NORTH;
    case (cmd[CMD_HDG_MSB:CMD_HDG_LSB])
      HDG_NORTH: hdg_dir = DIR_NORTH;
      HDG_WEST:  hdg_dir = DIR_WEST;
      HDG_SOUTH: hdg_dir = DIR_SOUTH;
      HDG_EAST:  hdg_dir = DIR_EAST;
      default:   hdg_ok  = 1'b0;
    endcase
  end

  // New commands are taken only while idle
  assign busy = (state != IDLE);

  //////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      dec_req     <= 1'b0;
      dec_dir     <= DIR_NORTH;
      dec_squares <= '0;
      tour_go     <= 1'b0;
      tour_index  <= '0;
      resp        <= RESP_NAK;
      resp_rdy    <= 1'b0;
      cal_cnt     <= '0;
    end else begin
      tour_go  <= 1'b0;
      resp_rdy <= 1'b0;
      case (state)
        IDLE: begin
          if (cmd_rdy) begin
            // A bad heading or opcode is answered in the next cycle
            if (!hdg_ok) begin
              resp  <= RESP_NAK;
              state <= RESPOND;
            end else begin
              case (op)
                OP_CAL_GYRO: begin
                  cal_cnt <= '0;
                  state   <= CAL;
                end
                OP_MOVE: begin
                  dec_req     <= 1'b1;
                  dec_dir     <= hdg_dir;
                  dec_squares <= cmd[CMD_ARG_MSB:CMD_ARG_LSB];
                  state       <= MOVE_WAIT;
                end
                OP_KNIGHT: begin
                  tour_go    <= 1'b1;
                  tour_index <= cmd[CMD_ARG_LSB+KNIGHT_IDX_W-1:CMD_ARG_LSB];
                  state      <= TOUR_WAIT;
                end
                default: begin
                  resp  <= RESP_NAK;
                  state <= RESPOND;
                end
              endcase
            end
          end
        end
        CAL: begin
          // The gyro settles for a fixed time and always succeeds
          if (cal_cnt == CAL_CNT_W'(CAL_CYCLES - 1)) begin
            resp  <= RESP_ACK;
            state <= RESPOND;
          end else begin
            cal_cnt <= cal_cnt + 1'b1;
          end
        end
        MOVE_WAIT: begin
          // Drop the request once the arbiter has taken it
          if (dec_grant) dec_req <= 1'b0;
          if (dec_done) begin
            resp  <= dec_clipped ? RESP_NAK : RESP_ACK;
            state <= RESPOND;
          end
        end
        TOUR_WAIT: begin
          if (leg_done_all) begin
            resp  <= leg_clipped ? RESP_NAK : RESP_ACK;
            state <= RESPOND;
          end
        end
        RESPOND: begin
          resp_rdy <= 1'b1;
          state    <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/tour_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Runs one knight move as a long leg followed by a short leg
module tour_sequencer
  import knight_board_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    tour_go,
  input  wire logic [KNIGHT_IDX_W-1:0] tour_index,
  input  wire logic                    tour_grant,
  input  wire logic                    tour_done,
  input  wire logic                    tour_clipped,
  output logic                         tour_req,
  output dir_t                         tour_dir,
  output logic [SQ_W-1:0]              tour_squares,
  output logic                         leg_done_all,
  output logic                         leg_clipped
);

  typedef enum logic [1:0] {IDLE, LONG_LEG, SHORT_LEG} tour_state_t;

  tour_state_t             state;
  logic [KNIGHT_IDX_W-1:0] idx;
  logic                    clip_acc;
  dir_t                    long_dir;
  dir_t                    short_dir;

  //////////////////////////////////////////////////
  // Leg lookup
  //////////////////////////////////////////////////
  // Bit 2 picks the axis of the long leg, bit 1 its sign, bit 0 the short sign
  always_comb begin
    if (idx[2]) begin
      long_dir  = idx[1] ? DIR_WEST : DIR_EAST;
      short_dir = idx[0] ? DIR_SOUTH : DIR_NORTH;
    end else begin
      long_dir  = idx[1] ? DIR_SOUTH : DIR_NORTH;
      short_dir = idx[0] ? DIR_WEST : DIR_EAST;
    end
  end

  // Request data follows the leg in progress and is stable while requesting
  assign tour_dir     = (state == SHORT_LEG) ? short_dir : long_dir;
  assign tour_squares = (state == SHORT_LEG) ? KNIGHT_SHORT : KNIGHT_LONG;

  always_ff @(posedge clk) begin
    if (tour_go && state == IDLE) idx <= tour_index;
  end

  //////////////////////////////////////////////////
  // Leg FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      tour_req     <= 1'b0;
      clip_acc     <= 1'b0;
      leg_done_all <= 1'b0;
      leg_clipped  <= 1'b0;
    end else begin
      leg_done_all <= 1'b0;
      case (state)
        IDLE: begin
          if (tour_go) begin
            clip_acc <= 1'b0;
            tour_req <= 1'b1;
            state    <= LONG_LEG;
          end
        end
        LONG_LEG: begin
          if (tour_grant) tour_req <= 1'b0;
          // The short leg still runs after a clipped long leg
          if (tour_done) begin
            clip_acc <= tour_clipped;
            tour_req <= 1'b1;
            state    <= SHORT_LEG;
          end
        end
        SHORT_LEG: begin
          if (tour_grant) tour_req <= 1'b0;
          if (tour_done) begin
            leg_done_all <= 1'b1;
            leg_clipped  <= clip_acc | tour_clipped;
            state        <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/move_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Shares the move executor between the decoder and the tour sequencer
module move_arbiter
  import knight_board_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            dec_req,
  input  wire dir_t            dec_dir,
  input  wire logic [SQ_W-1:0] dec_squares,
  input  wire logic            tour_req,
  input  wire dir_t            tour_dir,
  input  wire logic [SQ_W-1:0] tour_squares,
  input  wire logic            exe_done,
  input  wire logic            exe_clipped,
  output logic                 dec_grant,
  output logic                 tour_grant,
  output logic                 exe_start,
  output dir_t                 exe_dir,
  output logic [SQ_W-1:0]      exe_squares,
  output logic                 dec_done,
  output logic                 dec_clipped,
  output logic                 tour_done,
  output logic                 tour_clipped
);

  // Set from grant to completion so only one move is ever in flight
  logic     in_flight;
  req_tag_t owner;

  //////////////////////////////////////////////////
  // Grant and completion routing
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight  <= 1'b0;
      owner      <= REQ_DECODER;
      dec_grant  <= 1'b0;
      tour_grant <= 1'b0;
      exe_start  <= 1'b0;
      dec_done   <= 1'b0;
      tour_done  <= 1'b0;
    end else begin
      dec_grant  <= 1'b0;
      tour_grant <= 1'b0;
      exe_start  <= 1'b0;
      dec_done   <= 1'b0;
      tour_done  <= 1'b0;
      if (in_flight) begin
        if (exe_done) begin
          in_flight <= 1'b0;
          if (owner == REQ_TOUR) tour_done <= 1'b1;
          else dec_done <= 1'b1;
        end
      end else if (tour_req) begin
        // Tour legs win so a knight move is never split by a decoder move
        tour_grant <= 1'b1;
        exe_start  <= 1'b1;
        owner      <= REQ_TOUR;
        in_flight  <= 1'b1;
      end else if (dec_req) begin
        dec_grant <= 1'b1;
        exe_start <= 1'b1;
        owner     <= REQ_DECODER;
        in_flight <= 1'b1;
      end
    end
  end

  // Move data is captured alongside the grant and held while in flight
  always_ff @(posedge clk) begin
    if (!in_flight) begin
      exe_dir     <= tour_req ? tour_dir : dec_dir;
      exe_squares <= tour_req ? tour_squares : dec_squares;
    end
    if (exe_done) begin
      dec_clipped  <= exe_clipped;
      tour_clipped <= exe_clipped;
    end
  end

endmodule

`default_nettype wire

// ==== source/move_executor.sv ====
`timescale 1ns/1ps
`default_nettype none

// Steps the robot square by square and stops at the board edge
module move_executor
  import knight_board_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            exe_start,
  input  wire dir_t            exe_dir,
  input  wire logic [SQ_W-1:0] exe_squares,
  output logic                 exe_done,
  output logic                 exe_clipped,
  output logic [COORD_W-1:0]   xx,
  output logic [COORD_W-1:0]   yy
);

  logic                active;
  dir_t                dir_q;
  logic [SQ_W-1:0]     rem;
  logic [SQ_TMR_W-1:0] sq_tmr;
  logic [COORD_W-1:0]  step_xx;
  logic [COORD_W-1:0]  step_yy;

  // True when one more step in direction d would leave the board
  function automatic logic at_edge(input dir_t d, input logic [COORD_W-1:0] x,
                                   input logic [COORD_W-1:0] y);
    case (d)
      DIR_NORTH: at_edge = (y == BOARD_MAX);
      DIR_SOUTH: at_edge = (y == '0);
      DIR_EAST:  at_edge = (x == BOARD_MAX);
      default:   at_edge = (x == '0);
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Position after the next square
  //////////////////////////////////////////////////
  // North and east count up, south and west count down
  always_comb begin
    step_xx = xx;
    step_yy = yy;
    case (dir_q)
      DIR_NORTH: step_yy = yy + COORD_W'(1);
      DIR_SOUTH: step_yy = yy - COORD_W'(1);
      DIR_EAST:  step_xx = xx + COORD_W'(1);
      default:   step_xx = xx - COORD_W'(1);
    endcase
  end

  always_ff @(posedge clk) begin
    if (exe_start) dir_q <= exe_dir;
  end

  //////////////////////////////////////////////////
  // Square timer and stepping
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      active      <= 1'b0;
      rem         <= '0;
      sq_tmr      <= '0;
      exe_done    <= 1'b0;
      exe_clipped <= 1'b0;
      xx          <= START_XX;
      yy          <= START_YY;
    end else begin
      exe_done <= 1'b0;
      if (exe_start) begin
        rem <= exe_squares;
        // The start cycle counts as the first cycle of the first square
        sq_tmr <= SQ_TMR_W'(1);
        if (exe_squares == '0) begin
          exe_done    <= 1'b1;
          exe_clipped <= 1'b0;
        end else if (at_edge(exe_dir, xx, yy)) begin
          // Already against the edge, so nothing moves
          exe_done    <= 1'b1;
          exe_clipped <= 1'b1;
        end else begin
          active <= 1'b1;
        end
      end else if (active) begin
        if (sq_tmr == SQ_TMR_W'(SQUARE_CYCLES - 1)) begin
          xx     <= step_xx;
          yy     <= step_yy;
          rem    <= rem - 1'b1;
          sq_tmr <= '0;
          if (rem == SQ_W'(1)) begin
            active      <= 1'b0;
            exe_done    <= 1'b1;
            exe_clipped <= 1'b0;
          end else if (at_edge(dir_q, step_xx, step_yy)) begin
            // Squares are left but the next one is off the board
            active      <= 1'b0;
            exe_done    <= 1'b1;
            exe_clipped <= 1'b1;
          end
        end else begin
          sq_tmr <= sq_tmr + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/knights_tour_cmd.sv ====
`timescale 1ns/1ps
`default_nettype none

// Command and motion core of the knight robot
module knights_tour_cmd
  import knight_board_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic [15:0]        cmd,
  input  wire logic               cmd_rdy,
  output logic                    busy,
  output logic [7:0]              resp,
  output logic                    resp_rdy,
  output logic [COORD_W-1:0]      xx,
  output logic [COORD_W-1:0]      yy
);

  // Decoder and sequencer side of the arbiter
  logic                    dec_req, dec_grant, dec_done, dec_clipped;
  dir_t                    dec_dir;
  logic [SQ_W-1:0]         dec_squares;
  logic                    tour_req, tour_grant, tour_done, tour_clipped;
  dir_t                    tour_dir;
  logic [SQ_W-1:0]         tour_squares;
  logic                    tour_go, leg_done_all, leg_clipped;
  logic [KNIGHT_IDX_W-1:0] tour_index;
  // Executor side
  logic                    exe_start, exe_done, exe_clipped;
  dir_t                    exe_dir;
  logic [SQ_W-1:0]         exe_squares;

  cmd_decoder i_decoder (
    .clk(clk), .rst(rst), .cmd(cmd), .cmd_rdy(cmd_rdy),
    .dec_grant(dec_grant), .dec_done(dec_done), .dec_clipped(dec_clipped),
    .leg_done_all(leg_done_all), .leg_clipped(leg_clipped),
    .busy(busy), .dec_req(dec_req), .dec_dir(dec_dir), .dec_squares(dec_squares),
    .tour_go(tour_go), .tour_index(tour_index), .resp(resp), .resp_rdy(resp_rdy)
  );

  tour_sequencer i_tour (
    .clk(clk), .rst(rst), .tour_go(tour_go), .tour_index(tour_index),
    .tour_grant(tour_grant), .tour_done(tour_done), .tour_clipped(tour_clipped),
    .tour_req(tour_req), .tour_dir(tour_dir), .tour_squares(tour_squares),
    .leg_done_all(leg_done_all), .leg_clipped(leg_clipped)
  );

  move_arbiter i_arbiter (
    .clk(clk), .rst(rst),
    .dec_req(dec_req), .dec_dir(dec_dir), .dec_squares(dec_squares),
    .tour_req(tour_req), .tour_dir(tour_dir), .tour_squares(tour_squares),
    .exe_done(exe_done), .exe_clipped(exe_clipped),
    .dec_grant(dec_grant), .tour_grant(tour_grant),
    .exe_start(exe_start), .exe_dir(exe_dir), .exe_squares(exe_squares),
    .dec_done(dec_done), .dec_clipped(dec_clipped),
    .tour_done(tour_done), .tour_clipped(tour_clipped)
  );

  move_executor i_executor (
    .clk(clk), .rst(rst), .exe_start(exe_start), .exe_dir(exe_dir),
    .exe_squares(exe_squares), .exe_done(exe_done), .exe_clipped(exe_clipped),
    .xx(xx), .yy(yy)
  );

endmodule

`default_nettype wire

// ==== verification/knights_tour_cmd_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

// Grant, executor and response pulse rules of the command core
module knights_tour_cmd_assertions (
  input wire logic clk,
  input wire logic rst,
  input wire logic dec_grant,
  input wire logic tour_grant,
  input wire logic exe_start,
  input wire logic exe_done,
  input wire logic resp_rdy
);

  // High from a start pulse until the executor reports done
  logic moving;

  always_ff @(posedge clk) begin
    if (rst) moving <= 1'b0;
    else if (exe_start) moving <= 1'b1;
    else if (exe_done) moving <= 1'b0;
  end

  //////////////////////////////////////////////////
  // Protocol rules
  //////////////////////////////////////////////////
  one_grant: assert property (@(posedge clk) disable iff (rst) !(dec_grant && tour_grant))
    else $error("both requesters granted in the same cycle");

  // A second move must not start before the first one is done
  start_when_free: assert property (@(posedge clk) disable iff (rst) exe_start |-> !moving)
    else $error("exe_start while a move is in flight");

  resp_pulse: assert property (@(posedge clk) disable iff (rst) resp_rdy |=> !resp_rdy)
    else $error("resp_rdy held for more than one cycle");

endmodule

`default_nettype wire

// ==== verification/knights_tour_cmd_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Models position, clipping and responses and compares them with the DUT
module knights_tour_cmd_checker
  import knight_cmd_pkg::*, knight_board_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic [15:0]        cmd,
  input  wire logic               cmd_rdy,
  input  wire logic               busy,
  input  wire logic [7:0]         resp,
  input  wire logic               resp_rdy,
  input  wire logic [COORD_W-1:0] xx,
  input  wire logic [COORD_W-1:0] yy,
  input  wire logic               exp_known,
  input  wire logic [7:0]         exp_resp,
  input  wire logic [COORD_W-1:0] exp_xx,
  input  wire logic [COORD_W-1:0] exp_yy,
  output int                      check_count,
  output int                      error_count
);

  // No command may take longer than a calibration plus three long moves
  localparam int RESP_LIMIT = CAL_CYCLES + 3 * 5 * SQUARE_CYCLES + 20;

  int         mx;
  int         my;
  logic       mclip;
  logic [7:0] m_resp;
  logic       pending;
  logic       rst_q;
  int         cycle;
  int         accept_cycle;
  int         fixed_lat;

  initial begin
    check_count = 0;
    error_count = 0;
    cycle       = 0;
  end

  task automatic report(input string msg);
    error_count = error_count + 1;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////
  // Board model
  //////////////////////////////////////////////////
  // Steps square by square and stops short of the edge
  task automatic run_leg(input dir_t d, input int n);
    int left;
    left = n;
    while (left > 0) begin
      if ((d == DIR_NORTH && my == BOARD_MAX) || (d == DIR_SOUTH && my == 0) ||
          (d == DIR_EAST && mx == BOARD_MAX) || (d == DIR_WEST && mx == 0)) begin
        mclip = 1'b1;
        left  = 0;
      end else begin
        case (d)
          DIR_NORTH: my = my + 1;
          DIR_SOUTH: my = my - 1;
          DIR_EAST:  mx = mx + 1;
          default:   mx = mx - 1;
        endcase
        left = left - 1;
      end
    end
  endtask

  // Long leg of two squares, then the short leg of one
  task automatic run_knight(input logic [2:0] idx);
    dir_t ld;
    dir_t sd;
    case (idx)
      3'd0: begin ld = DIR_NORTH; sd = DIR_EAST;  end
      3'd1: begin ld = DIR_NORTH; sd = DIR_WEST;  end
      3'd2: begin ld = DIR_SOUTH; sd = DIR_EAST;  end
      3'd3: begin ld = DIR_SOUTH; sd = DIR_WEST;  end
      3'd4: begin ld = DIR_EAST;  sd = DIR_NORTH; end
      3'd5: begin ld = DIR_EAST;  sd = DIR_SOUTH; end
      3'd6: begin ld = DIR_WEST;  sd = DIR_NORTH; end
      default: begin ld = DIR_WEST; sd = DIR_SOUTH; end
    endcase
    run_leg(ld, 2);
    run_leg(sd, 1);
  endtask

  // Works out the response and latency of a command the DUT has just taken
  task automatic accept(input logic [15:0] c);
    logic hdg_ok;
    dir_t d;
    hdg_ok    = 1'b1;
    d         = DIR_NORTH;
    mclip     = 1'b0;
    fixed_lat = -1;
    case (c[CMD_HDG_MSB:CMD_HDG_LSB])
      HDG_NORTH: d = DIR_NORTH;
      HDG_WEST:  d = DIR_WEST;
      HDG_SOUTH: d = DIR_SOUTH;
      HDG_EAST:  d = DIR_EAST;
      default:   hdg_ok = 1'b0;
    endcase
    if (!hdg_ok) begin
      m_resp    = RESP_NAK;
      fixed_lat = 2;
    end else begin
      case (c[CMD_OP_MSB:CMD_OP_LSB])
        OP_CAL_GYRO: begin
          m_resp    = RESP_ACK;
          fixed_lat = CAL_CYCLES + 2;
        end
        OP_MOVE: begin
          run_leg(d, c[CMD_ARG_MSB:CMD_ARG_LSB]);
          m_resp = mclip ? RESP_NAK : RESP_ACK;
        end
        OP_KNIGHT: begin
          run_knight(c[CMD_ARG_LSB+2:CMD_ARG_LSB]);
          m_resp = mclip ? RESP_NAK : RESP_ACK;
        end
        default: begin
          m_resp    = RESP_NAK;
          fixed_lat = 2;
        end
      endcase
    end
  endtask

  //////////////////////////////////////////////////
  // Port monitor
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst) begin
      mx      = START_XX;
      my      = START_YY;
      pending = 1'b0;
    end else begin
      // First cycle out of reset
      if (rst_q) begin
        check_count = check_count + 1;
        if (busy || resp_rdy || xx !== START_XX || yy !== START_YY)
          report($sformatf("after reset busy=%b resp_rdy=%b pos=(%0d,%0d)",
                           busy, resp_rdy, xx, yy));
      end
      if (resp_rdy) begin
        if (!pending) begin
          error_count = error_count + 1;
          $display("Error: response %h arrived with no command outstanding", resp);
        end else begin
          check_count = check_count + 1;
          if (resp !== m_resp)
            report($sformatf("resp %h, model expects %h", resp, m_resp));
          if (xx !== COORD_W'(mx) || yy !== COORD_W'(my))
            report($sformatf("position (%0d,%0d), model expects (%0d,%0d)", xx, yy, mx, my));
          if (exp_known && (resp !== exp_resp || xx !== exp_xx || yy !== exp_yy))
            report($sformatf("resp %h at (%0d,%0d), table expects %h at (%0d,%0d)",
                             resp, xx, yy, exp_resp, exp_xx, exp_yy));
          if (fixed_lat >= 0 && cycle - accept_cycle != fixed_lat)
            report($sformatf("response after %0d cycles, expected %0d",
                             cycle - accept_cycle, fixed_lat));
        end
        pending = 1'b0;
      end else if (pending) begin
        if (!busy) report("busy dropped before the response");
        if (cycle - accept_cycle > RESP_LIMIT) begin
          error_count = error_count + 1;
          $display("Error: no response within %0d cycles of command %h", RESP_LIMIT, cmd);
          pending = 1'b0;
        end
      end
      // A strobe while busy is dropped by the DUT and so by the model
      if (cmd_rdy && !busy) begin
        accept(cmd);
        pending      = 1'b1;
        accept_cycle = cycle;
      end
    end
    rst_q = rst;
  end

endmodule

`default_nettype wire

// ==== verification/knights_tour_cmd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Drives the command core through a table of commands and reports the outcome
module knights_tour_cmd_tb
  import knight_cmd_pkg::*, knight_board_pkg::*;
();

  localparam int FIXED_N    = 22;
  localparam int RAND_N     = 8;
  localparam int ENTRY_N    = FIXED_N + RAND_N;
  localparam int RST_CYCLES = 10;
  // Worst case per entry is a calibration or a long move plus idle gaps
  localparam int CYCLE_LIMIT =
    ENTRY_N * (CAL_CYCLES + 3 * 5 * SQUARE_CYCLES + 20) + RST_CYCLES;

  logic               clk;
  logic               rst;
  logic [15:0]        cmd;
  logic               cmd_rdy;
  logic               busy;
  logic [7:0]         resp;
  logic               resp_rdy;
  logic [COORD_W-1:0] xx;
  logic [COORD_W-1:0] yy;

  // Expected values of the entry in progress for the checker
  logic               exp_known;
  logic [7:0]         exp_resp;
  logic [COORD_W-1:0] exp_xx;
  logic [COORD_W-1:0] exp_yy;
  int                 check_count;
  int                 error_count;
  int                 cycle;

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////
  logic [15:0]        tbl_cmd   [ENTRY_N];
  logic               tbl_poke  [ENTRY_N];
  logic               tbl_known [ENTRY_N];
  logic [7:0]         tbl_resp  [ENTRY_N];
  logic [COORD_W-1:0] tbl_xx    [ENTRY_N];
  logic [COORD_W-1:0] tbl_yy    [ENTRY_N];

  knights_tour_cmd DUT (
    .clk(clk), .rst(rst), .cmd(cmd), .cmd_rdy(cmd_rdy), .busy(busy),
    .resp(resp), .resp_rdy(resp_rdy), .xx(xx), .yy(yy)
  );

  knights_tour_cmd_checker scoreboard (
    .clk(clk), .rst(rst), .cmd(cmd), .cmd_rdy(cmd_rdy), .busy(busy),
    .resp(resp), .resp_rdy(resp_rdy), .xx(xx), .yy(yy),
    .exp_known(exp_known), .exp_resp(exp_resp), .exp_xx(exp_xx), .exp_yy(exp_yy),
    .check_count(check_count), .error_count(error_count)
  );

  // Protocol rules sit at the top level where grants, executor and response meet
  bind knights_tour_cmd knights_tour_cmd_assertions protocol_checks (
    .clk(clk), .rst(rst), .dec_grant(dec_grant), .tour_grant(tour_grant),
    .exe_start(exe_start), .exe_done(exe_done), .resp_rdy(resp_rdy)
  );

  // One table row with its expected response and final position
  task automatic set_entry(input int i, input logic [15:0] c, input logic poke,
                           input logic [7:0] r, input int x, input int y);
    tbl_cmd[i]   = c;
    tbl_poke[i]  = poke;
    tbl_known[i] = 1'b1;
    tbl_resp[i]  = r;
    tbl_xx[i]    = COORD_W'(x);
    tbl_yy[i]    = COORD_W'(y);
  endtask

  task automatic load_table();
    // Calibration with a second strobe sent while busy
    set_entry(0, 16'h2000, 1'b1, RESP_ACK, 2, 2);
    // Single squares out of the center and back
    set_entry(1, 16'h43F1, 1'b0, RESP_ACK, 1, 2);
    set_entry(2, 16'h4BF1, 1'b0, RESP_ACK, 2, 2);
    set_entry(3, 16'h4BF1, 1'b0, RESP_ACK, 3, 2);
    set_entry(4, 16'h43F1, 1'b0, RESP_ACK, 2, 2);
    set_entry(5, 16'h4001, 1'b0, RESP_ACK, 2, 3);
    set_entry(6, 16'h47F1, 1'b0, RESP_ACK, 2, 2);
    set_entry(7, 16'h47F1, 1'b0, RESP_ACK, 2, 1);
    set_entry(8, 16'h47F1, 1'b0, RESP_ACK, 2, 0);
    // Full column north, then a move against the top edge
    set_entry(9, 16'h4004, 1'b0, RESP_ACK, 2, 4);
    set_entry(10, 16'h4001, 1'b0, RESP_NAK, 2, 4);
    // Knight moves by fixed index
    set_entry(11, 16'h6002, 1'b0, RESP_ACK, 3, 2);
    set_entry(12, 16'h6007, 1'b0, RESP_ACK, 1, 1);
    set_entry(13, 16'h6004, 1'b0, RESP_ACK, 3, 2);
    set_entry(14, 16'h6000, 1'b0, RESP_ACK, 4, 4);
    set_entry(15, 16'h6000, 1'b0, RESP_NAK, 4, 4);
    set_entry(16, 16'h6006, 1'b0, RESP_NAK, 2, 4);
    // Bad opcode and bad heading
    set_entry(17, 16'h1001, 1'b0, RESP_NAK, 2, 4);
    set_entry(18, 16'h4121, 1'b0, RESP_NAK, 2, 4);
    // Zero squares, a move clipped half way, then back down
    set_entry(19, 16'h4BF0, 1'b0, RESP_ACK, 2, 4);
    set_entry(20, 16'h4BF5, 1'b0, RESP_NAK, 4, 4);
    set_entry(21, 16'h47F3, 1'b0, RESP_ACK, 4, 1);
    // Random knight indices are judged by the checker model alone
    for (int i = FIXED_N; i < ENTRY_N; i++) begin
      tbl_cmd[i]   = {OP_KNIGHT, HDG_NORTH, 4'($urandom % 8)};
      tbl_poke[i]  = 1'b0;
      tbl_known[i] = 1'b0;
      tbl_resp[i]  = RESP_NAK;
      tbl_xx[i]    = '0;
      tbl_yy[i]    = '0;
    end
  endtask

  //////////////////////////////////////////////////
  // Applying one entry
  //////////////////////////////////////////////////
  task automatic apply_entry(input int i);
    @(posedge clk);
    cmd       <= tbl_cmd[i];
    cmd_rdy   <= 1'b1;
    exp_known <= tbl_known[i];
    exp_resp  <= tbl_resp[i];
    exp_xx    <= tbl_xx[i];
    exp_yy    <= tbl_yy[i];
    @(posedge clk);
    cmd_rdy <= 1'b0;
    if (tbl_poke[i]) begin
      // This move must be dropped since the decoder is still calibrating
      repeat (4) @(posedge clk);
      cmd     <= {OP_MOVE, HDG_NORTH, 4'd1};
      cmd_rdy <= 1'b1;
      @(posedge clk);
      cmd_rdy <= 1'b0;
    end
    while (!resp_rdy) @(posedge clk);
    // Idle gap lets a stray extra response show up in the checker
    repeat (3) @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  initial begin
    wait (cycle >= CYCLE_LIMIT);
    $display("Timeout after %0d cycles with the command table unfinished", cycle);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst       = 1'b1;
    cmd       = '0;
    cmd_rdy   = 1'b0;
    exp_known = 1'b0;
    exp_resp  = '0;
    exp_xx    = '0;
    exp_yy    = '0;
    void'($urandom(26299));
    load_table();
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < ENTRY_N; i++) begin
      apply_entry(i);
    end
    repeat (4) @(posedge clk);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/knight_cmd_pkg.sv
source/knight_board_pkg.sv
source/cmd_decoder.sv
source/tour_sequencer.sv
source/move_arbiter.sv
source/move_executor.sv
source/knights_tour_cmd.sv
verification/knights_tour_cmd_assertions.sv
verification/knights_tour_cmd_checker.sv
verification/knights_tour_cmd_tb.sv

// ==== Makefile ====
SIM        ?= verilator
TOP        ?= knights_tour_cmd_tb
FILELIST   ?= list.f
FLAGS      ?= --binary --assert -Wno-fatal --top-module $(TOP)
LINT_FLAGS ?= --lint-only -Wall --top-module $(TOP)
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
